//--- common/ufiBusPkg.sv
/*
 * UFI bus widths, the address region of this master and the read DMA limits.
 * Imported by every block that drives or decodes a bus address or data word.
 */
`default_nettype none

package ufiBusPkg;

	// ------------------------------
	// Bus geometry
	// ------------------------------
	// Data word width
	localparam int UFI_DQ_WIDTH = 16;
	// Full bus address width
	localparam int UFI_ADRS_WIDTH = 32;
	// Region nibble placed in bits 31..28
	localparam logic [3:0] UFI_ADRS_MAP = 4'h2;

	// ------------------------------
	// DMA limits
	// ------------------------------
	// SRAM word address, sits in the low bits of the bus address
	localparam int DMA_ADRS_WIDTH = 18;
	// Reads in flight before the request level drops
	localparam int DMA_MAX_OUTSTANDING = 4;

	// Bus data word
	typedef logic [UFI_DQ_WIDTH-1:0] ufiData_t;
	// Bus address as seen on the wire
	typedef logic [UFI_ADRS_WIDTH-1:0] ufiAdrs_t;
	// SRAM word address
	typedef logic [DMA_ADRS_WIDTH-1:0] dmaAdrs_t;

endpackage

`default_nettype wire

//--- common/mapChipPkg.sv
/*
 * Map chip geometry, line buffer layout and the read DMA state encoding.
 * A chip is 32 x 32 pixels, one line of it fills one 32-word line buffer slot.
 */
`default_nettype none

package mapChipPkg;

	// ------------------------------
	// Chip geometry
	// ------------------------------
	// Pixels per chip side, also words per line
	localparam int CHIP_SIZE = 32;
	// Line number or word index within a line
	localparam int CHIP_LINE_BITS = 5;
	// Chip ID width
	localparam int CHIP_ID_BITS = 8;

	// Word address rule: (id << 10) + (line << 5)
	localparam int CHIP_ID_SHIFT = 10;
	localparam int CHIP_LINE_SHIFT = 5;

	// ------------------------------
	// Line buffer
	// ------------------------------
	// Eight slots of one chip line each
	localparam int LINE_SLOTS = 8;
	localparam int SLOT_BITS = 3;
	// Pixel read address, slot in the top bits
	localparam int LINEBUF_ADRS_BITS = 8;
	localparam int LINEBUF_DEPTH = LINE_SLOTS * CHIP_SIZE;

	typedef logic [CHIP_ID_BITS-1:0] chipId_t;
	typedef logic [CHIP_LINE_BITS-1:0] chipLine_t;
	typedef logic [SLOT_BITS-1:0] slot_t;
	typedef logic [LINEBUF_ADRS_BITS-1:0] pixAdrs_t;

	// Read DMA sequencing
	typedef enum logic [1:0]
	{
		DMA_IDLE,	// waiting for a queued command
		DMA_RUN,	// issuing addresses
		DMA_DRAIN	// all issued, late words still due
	} dmaState_t;

endpackage

`default_nettype wire

//--- common/chipFetchIf.sv
/*
 * Links inside the fetcher: the command from the request queue to the DMA,
 * and the word stream from the DMA into the line buffer.
 */
`timescale 1ns/10ps
`default_nettype none

// Queue head toward the DMA, popped by a one-cycle cmdTake
interface chipCmdIf
	import ufiBusPkg::*, mapChipPkg::*;
;
	logic cmdValid;
	dmaAdrs_t cmdStart;
	slot_t cmdSlot;
	logic cmdTake;

	modport source (output cmdValid, output cmdStart, output cmdSlot, input cmdTake);
	modport sink (input cmdValid, input cmdStart, input cmdSlot, output cmdTake);
endinterface

// One word per wrEn, wrLast on word 31
interface pixWrIf
	import ufiBusPkg::*, mapChipPkg::*;
;
	logic wrEn;
	ufiData_t wrData;
	slot_t wrSlot;
	chipLine_t wrIndex;
	logic wrLast;

	modport source (output wrEn, output wrData, output wrSlot, output wrIndex, output wrLast);
	modport sink (input wrEn, input wrData, input wrSlot, input wrIndex, input wrLast);
endinterface

`default_nettype wire

//--- hdl/chipAdrsGen.sv
/*
 * Request side of the fetcher. Takes chip line requests from the pixel
 * pipeline, works out the SRAM start address and queues up to two of them.
 */
`timescale 1ns/10ps
`default_nettype none

module chipAdrsGen
	import ufiBusPkg::*, mapChipPkg::*;
(
	input wire logic iCLK,
	input wire logic rstN,
	// Pixel pipeline request
	input wire logic reqStrobe,
	input wire chipId_t reqChipId,
	input wire chipLine_t reqLine,
	input wire slot_t reqSlot,
	output logic reqFull,
	// Queue head toward the DMA
	chipCmdIf.source cmd
);

	// ------------------------------
	// Start address
	// ------------------------------
	dmaAdrs_t startAdrs;

	// Chip base plus line offset, 8+10 bits fill the SRAM word address
	assign startAdrs = (dmaAdrs_t'(reqChipId) << CHIP_ID_SHIFT)
		+ (dmaAdrs_t'(reqLine) << CHIP_LINE_SHIFT);

	// ------------------------------
	// Two-entry queue
	// ------------------------------
	dmaAdrs_t qStart [0:1];
	slot_t qSlot [0:1];
	logic wrPtr;
	logic rdPtr;
	logic [1:0] count;
	logic push;
	logic pop;

	assign reqFull = (count == 2'd2);
	// Strobes while full are lost
	assign push = reqStrobe && !reqFull;
	assign pop = cmd.cmdTake && (count != 2'd0);

	// Entry storage
	always_ff @(posedge iCLK)
	begin
		if (push)
		begin
			qStart[wrPtr] <= startAdrs;
			qSlot[wrPtr] <= reqSlot;
		end
	end

	// Pointers and fill level
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			count <= 2'd0;
		end
		else
		begin
			if (push)
				wrPtr <= ~wrPtr;
			if (pop)
				rdPtr <= ~rdPtr;
			// Push and pop together leave the level alone
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	// Head entry, valid whenever something is queued
	assign cmd.cmdValid = (count != 2'd0);
	assign cmd.cmdStart = qStart[rdPtr];
	assign cmd.cmdSlot = qSlot[rdPtr];

endmodule

`default_nettype wire

//--- dma/ufiReadDma.sv
/*
 * UFI read DMA for one chip line. Issues 32 pipelined reads, at most four in
 * flight, and passes each returned word on with its slot and word index.
 */
`timescale 1ns/10ps
`default_nettype none

module ufiReadDma
	import ufiBusPkg::*, mapChipPkg::*;
(
	input wire logic iCLK,
	input wire logic rstN,
	// Command from the request queue
	chipCmdIf.sink cmd,
	// UFI master read
	output ufiAdrs_t ufiAdrs,
	output logic ufiRe,
	input wire logic ufiRdy,
	input wire ufiData_t ufiRd,
	input wire logic ufiRvd,
	// Words toward the line buffer
	pixWrIf.source wr
);

	dmaState_t state;
	dmaAdrs_t issueAdrs;
	dmaAdrs_t endAdrs;
	slot_t curSlot;
	chipLine_t rxIndex;
	logic [$clog2(DMA_MAX_OUTSTANDING+1)-1:0] outstanding;
	logic accept;
	logic lastIssue;
	logic lastWord;

	// ------------------------------
	// Bus side
	// ------------------------------
	// Pop only when idle, so one command at a time
	assign cmd.cmdTake = (state == DMA_IDLE) && cmd.cmdValid;

	// Request level, held while ufiRdy is low
	assign ufiRe = (state == DMA_RUN) && (outstanding < DMA_MAX_OUTSTANDING);
	assign accept = ufiRe && ufiRdy;

	// Region nibble, zero gap, word address
	assign ufiAdrs = {UFI_ADRS_MAP,
		{(UFI_ADRS_WIDTH - $bits(UFI_ADRS_MAP) - DMA_ADRS_WIDTH){1'b0}},
		issueAdrs};

	assign lastIssue = accept && (issueAdrs == endAdrs);
	assign lastWord = ufiRvd && (rxIndex == chipLine_t'(CHIP_SIZE - 1));

	// ------------------------------
	// State machine
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
			state <= DMA_IDLE;
		else
		begin
			case (state)
				DMA_IDLE:
					if (cmd.cmdValid)
						state <= DMA_RUN;
				DMA_RUN:
					if (lastIssue)
						state <= DMA_DRAIN;
				DMA_DRAIN:
					// word 31 back, line complete
					if (lastWord)
						state <= DMA_IDLE;
				default:
					state <= DMA_IDLE;
			endcase
		end
	end

	// Address walk, start to start + 31
	always_ff @(posedge iCLK)
	begin
		if (cmd.cmdTake)
		begin
			issueAdrs <= cmd.cmdStart;
			endAdrs <= cmd.cmdStart + dmaAdrs_t'(CHIP_SIZE - 1);
			curSlot <= cmd.cmdSlot;
		end
		else if (accept)
			issueAdrs <= issueAdrs + dmaAdrs_t'(1);
	end

	// Reads in flight and return tagging
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			outstanding <= '0;
			rxIndex <= '0;
		end
		else
		begin
			case ({accept, ufiRvd})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
			if (cmd.cmdTake)
				rxIndex <= '0;
			else if (ufiRvd)
				rxIndex <= rxIndex + chipLine_t'(1);
		end
	end

	// ------------------------------
	// Word stream, one cycle after ufiRvd
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			wr.wrEn <= 1'b0;
			wr.wrLast <= 1'b0;
		end
		else
		begin
			wr.wrEn <= ufiRvd;
			wr.wrLast <= lastWord;
		end
	end

	always_ff @(posedge iCLK)
	begin
		wr.wrData <= ufiRd;
		wr.wrIndex <= rxIndex;
		wr.wrSlot <= curSlot;
	end

endmodule

`default_nettype wire

//--- hdl/lineBufWriter.sv
/*
 * Output side. Keeps the 256-pixel line buffer, filled by the DMA word stream
 * and read back by the pixel pipeline one cycle after the address.
 */
`timescale 1ns/10ps
`default_nettype none

module lineBufWriter
	import ufiBusPkg::*, mapChipPkg::*;
(
	input wire logic iCLK,
	input wire logic rstN,
	// Word stream from the DMA
	pixWrIf.sink wr,
	// Pixel read port
	input wire pixAdrs_t pixRa,
	output ufiData_t pixRd,
	// End of a chip line
	output logic chipDone
);

	// ------------------------------
	// Buffer memory
	// ------------------------------
	ufiData_t lineMem [0:LINEBUF_DEPTH-1];
	pixAdrs_t wrAdrs;

	// Slot * 32 + index, as a concatenation
	assign wrAdrs = {wr.wrSlot, wr.wrIndex};

	// Write port
	always_ff @(posedge iCLK)
	begin
		if (wr.wrEn)
			lineMem[wrAdrs] <= wr.wrData;
	end

	// Registered read, no bypass of a same-cycle write
	always_ff @(posedge iCLK)
	begin
		pixRd <= lineMem[pixRa];
	end

	// ------------------------------
	// Completion
	// ------------------------------
	// High the cycle after word 31 lands
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
			chipDone <= 1'b0;
		else
			chipDone <= wr.wrEn && wr.wrLast;
	end

endmodule

`default_nettype wire

//--- hdl/videoChipFetch.sv
/*
 * Top of the tile line fetcher. Request queue, UFI read DMA and line buffer,
 * joined by the command and word-stream links. Plain ports only.
 */
`timescale 1ns/10ps
`default_nettype none

module videoChipFetch
	import ufiBusPkg::*, mapChipPkg::*;
(
	input wire logic iCLK,
	input wire logic rstN,
	// Pixel pipeline request
	input wire logic reqStrobe,
	input wire chipId_t reqChipId,
	input wire chipLine_t reqLine,
	input wire slot_t reqSlot,
	output logic reqFull,
	// UFI master read
	output ufiAdrs_t ufiAdrs,
	output logic ufiRe,
	input wire logic ufiRdy,
	input wire ufiData_t ufiRd,
	input wire logic ufiRvd,
	// Pixel read port
	input wire pixAdrs_t pixRa,
	output ufiData_t pixRd,
	output logic chipDone
);

	// ------------------------------
	// Internal links
	// ------------------------------
	chipCmdIf cmdLink();
	pixWrIf wrLink();

	// Requests in, start address out
	chipAdrsGen chipAdrsGen_inst (
		.iCLK(iCLK),
		.rstN(rstN),
		.reqStrobe(reqStrobe),
		.reqChipId(reqChipId),
		.reqLine(reqLine),
		.reqSlot(reqSlot),
		.reqFull(reqFull),
		.cmd(cmdLink.source)
	);

	// Bus reads of one line
	ufiReadDma ufiReadDma_inst (
		.iCLK(iCLK),
		.rstN(rstN),
		.cmd(cmdLink.sink),
		.ufiAdrs(ufiAdrs),
		.ufiRe(ufiRe),
		.ufiRdy(ufiRdy),
		.ufiRd(ufiRd),
		.ufiRvd(ufiRvd),
		.wr(wrLink.source)
	);

	// Line buffer and pixel port
	lineBufWriter lineBufWriter_inst (
		.iCLK(iCLK),
		.rstN(rstN),
		.wr(wrLink.sink),
		.pixRa(pixRa),
		.pixRd(pixRd),
		.chipDone(chipDone)
	);

endmodule

`default_nettype wire

//--- testbench/tbClockGen.sv
/*
 * Testbench clock and reset. 20 ns clock, reset low for the first five rising
 * edges. holdRst pulls reset low again for a reset in the middle of a test.
 */
`timescale 1ns/10ps
`default_nettype none

module tbClockGen
(
	input wire logic holdRst,
	output logic iCLK,
	output logic rstN
);

	logic powerOnN;

	// 50 MHz free-running clock
	initial
	begin
		iCLK = 1'b0;
		forever
			#10 iCLK = ~iCLK;
	end

	// Five edges in reset, released just after the fifth
	initial
	begin
		powerOnN = 1'b0;
		repeat (5)
			@(posedge iCLK);
		#1 powerOnN = 1'b1;
	end

	assign rstN = powerOnN && !holdRst;

endmodule

`default_nettype wire

//--- testbench/ufiSramModel.sv
/*
 * UFI slave model of the video SRAM. Accepts reads on ufiRe and ufiRdy, and
 * returns data in order after 1 to 4 cycles. stall holds ufiRdy low.
 */
`timescale 1ns/10ps
`default_nettype none

module ufiSramModel
	import ufiBusPkg::*;
(
	input wire logic iCLK,
	input wire logic rstN,
	input wire ufiAdrs_t ufiAdrs,
	input wire logic ufiRe,
	input wire logic stall,
	input wire logic randomMode,
	output logic ufiRdy,
	output ufiData_t ufiRd,
	output logic ufiRvd
);

	integer seed;
	int cycle;
	int lastDue;
	ufiData_t rdQueue [$];
	int dueQueue [$];
	// Inputs as seen mid-cycle
	logic accepted;
	logic resetSeen;
	logic stallSeen;
	logic randomSeen;
	ufiAdrs_t adrsSeen;

	// Memory content, (A * 3 + 0x1234) folded to 16 bits
	function automatic ufiData_t sramWord(input dmaAdrs_t sramAdrs);
		return ufiData_t'(sramAdrs * 3 + 'h1234);
	endfunction

	initial
	begin
		seed = 83;
		cycle = 0;
		lastDue = 0;
		ufiRdy = 1'b0;
		ufiRd = '0;
		ufiRvd = 1'b0;
	end

	// Sample at the falling edge, all inputs stable there
	always @(negedge iCLK)
	begin
		accepted = ufiRe && ufiRdy && rstN;
		adrsSeen = ufiAdrs;
		resetSeen = !rstN;
		stallSeen = stall;
		randomSeen = randomMode;
	end

	always @(posedge iCLK)
	begin
		int lat;
		int due;
		cycle++;
		if (resetSeen)
		begin
			// Reads in flight are lost on reset
			rdQueue.delete();
			dueQueue.delete();
			lastDue = cycle;
		end
		else if (accepted)
		begin
			lat = randomSeen ? 1 + ($unsigned($random(seed)) % 4) : 1;
			due = cycle + lat - 1;
			// In order, at most one word per cycle
			if (due <= lastDue)
				due = lastDue + 1;
			lastDue = due;
			rdQueue.push_back(sramWord(dmaAdrs_t'(adrsSeen)));
			dueQueue.push_back(due);
		end
		#1;
		ufiRvd = 1'b0;
		if (dueQueue.size() > 0 && dueQueue[0] <= cycle)
		begin
			ufiRvd = 1'b1;
			ufiRd = rdQueue.pop_front();
			void'(dueQueue.pop_front());
		end
		// Ready about three cycles in four when random
		if (stallSeen || resetSeen)
			ufiRdy = 1'b0;
		else if (randomSeen)
			ufiRdy = (($random(seed) & 3) != 0);
		else
			ufiRdy = 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/videoChipFetchTb.sv
/*
 * Directed testbench of the tile line fetcher. Drives chip line requests,
 * checks every bus read address and the line buffer content after chipDone.
 */
`timescale 1ns/10ps
`default_nettype none

module videoChipFetchTb
	import ufiBusPkg::*, mapChipPkg::*;
;

	logic iCLK;
	logic rstN;
	logic holdRst;
	logic reqStrobe;
	chipId_t reqChipId;
	chipLine_t reqLine;
	slot_t reqSlot;
	logic reqFull;
	ufiAdrs_t ufiAdrs;
	logic ufiRe;
	logic ufiRdy;
	ufiData_t ufiRd;
	logic ufiRvd;
	pixAdrs_t pixRa;
	ufiData_t pixRd;
	logic chipDone;
	logic stall;
	logic randomMode;

	int errors = 0;
	int checks = 0;
	int timeouts = 0;
	int doneCount = 0;
	int acceptCount = 0;
	// SRAM word addresses still due on the bus
	dmaAdrs_t expAdrs [$];
	dmaAdrs_t nextAdrs;
	logic holdSeen = 1'b0;
	ufiAdrs_t heldAdrs;

	tbClockGen clockGen_inst (
		.holdRst(holdRst),
		.iCLK(iCLK),
		.rstN(rstN)
	);

	ufiSramModel sramModel_inst (
		.iCLK(iCLK),
		.rstN(rstN),
		.ufiAdrs(ufiAdrs),
		.ufiRe(ufiRe),
		.stall(stall),
		.randomMode(randomMode),
		.ufiRdy(ufiRdy),
		.ufiRd(ufiRd),
		.ufiRvd(ufiRvd)
	);

	videoChipFetch videoChipFetch_inst (
		.iCLK(iCLK),
		.rstN(rstN),
		.reqStrobe(reqStrobe),
		.reqChipId(reqChipId),
		.reqLine(reqLine),
		.reqSlot(reqSlot),
		.reqFull(reqFull),
		.ufiAdrs(ufiAdrs),
		.ufiRe(ufiRe),
		.ufiRdy(ufiRdy),
		.ufiRd(ufiRd),
		.ufiRvd(ufiRvd),
		.pixRa(pixRa),
		.pixRd(pixRd),
		.chipDone(chipDone)
	);

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkPix(input string name, input ufiData_t got, input ufiData_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkAdrs(input string name, input ufiAdrs_t got, input ufiAdrs_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Pixel of a chip line from SRAM word (id * 1024 + line * 32 + i) * 3 + 0x1234
	function automatic ufiData_t expectedPixel(input chipId_t id, input chipLine_t line,
		input int i);
		int sramAdrs;
		sramAdrs = id * 1024 + line * 32 + i;
		return ufiData_t'(sramAdrs * 3 + 'h1234);
	endfunction

	// ------------------------------
	// Bus monitor
	// ------------------------------
	always @(negedge iCLK)
	begin
		if (!rstN)
		begin
			expAdrs.delete();
			holdSeen = 1'b0;
		end
		else
		begin
			// Stalled read must not move
			if (holdSeen)
			begin
				checkFlag("ufiRe", ufiRe, 1'b1);
				checkAdrs("ufiAdrs", ufiAdrs, heldAdrs);
			end
			if (chipDone)
				doneCount++;
			if (ufiRe && ufiRdy)
			begin
				acceptCount++;
				if (expAdrs.size() == 0)
				begin
					errors++;
					$display("Bus read at 0x%h came with no request pending", ufiAdrs);
				end
				else
				begin
					nextAdrs = expAdrs.pop_front();
					// Region 2 on top and the SRAM word address at the bottom
					checkAdrs("ufiAdrs", ufiAdrs, {UFI_ADRS_MAP, 10'h000, nextAdrs});
				end
			end
			holdSeen = ufiRe && !ufiRdy;
			heldAdrs = ufiAdrs;
		end
	end

	// ------------------------------
	// Driving helpers
	// ------------------------------
	// One strobe cycle that stays high into a following request
	task automatic sendRequest(input chipId_t id, input chipLine_t line, input slot_t slot,
		input logic expectFull);
		int i;
		@(posedge iCLK);
		#1;
		reqStrobe = 1'b1;
		reqChipId = id;
		reqLine = line;
		reqSlot = slot;
		@(negedge iCLK);
		checkFlag("reqFull", reqFull, expectFull);
		// Dropped when full
		if (!reqFull)
			for (i = 0; i < CHIP_SIZE; i++)
				expAdrs.push_back(dmaAdrs_t'(id * 1024 + line * 32 + i));
	endtask

	task automatic endRequest();
		@(posedge iCLK);
		#1 reqStrobe = 1'b0;
	endtask

	task automatic waitChipDone(input int target);
		int limit;
		limit = 0;
		while (doneCount < target && limit < 2000)
		begin
			@(posedge iCLK);
			limit++;
		end
		if (doneCount < target)
		begin
			timeouts++;
			$display("Timeout: only %0d of %0d chipDone pulses seen", doneCount, target);
		end
	endtask

	task automatic waitAccepts(input int target);
		int limit;
		limit = 0;
		while (acceptCount < target && limit < 500)
		begin
			@(posedge iCLK);
			limit++;
		end
		if (acceptCount < target)
		begin
			timeouts++;
			$display("Timeout: bus reads stopped at %0d of %0d", acceptCount, target);
		end
	endtask

	// Read back a slot through the pixel port with data one cycle after pixRa
	task automatic verifySlot(input slot_t slot, input chipId_t id, input chipLine_t line);
		int i;
		for (i = 0; i < CHIP_SIZE; i++)
		begin
			@(posedge iCLK);
			#1 pixRa = pixAdrs_t'(slot * 32 + i);
			@(posedge iCLK);
			@(negedge iCLK);
			checkPix($sformatf("pixRd[%0d]", pixRa), pixRd, expectedPixel(id, line, i));
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic singleFetchTest();
		int startDone;
		startDone = doneCount;
		// Chip 5 line 7 reads from 0x1400 + 0xE0
		sendRequest(8'd5, 5'd7, 3'd2, 1'b0);
		endRequest();
		waitChipDone(startDone + 1);
		verifySlot(3'd2, 8'd5, 5'd7);
	endtask

	task automatic backToBackTest();
		int startDone;
		startDone = doneCount;
		sendRequest(8'h10, 5'd0, 3'd4, 1'b0);
		sendRequest(8'h7F, 5'd31, 3'd5, 1'b0);
		sendRequest(8'hC3, 5'd12, 3'd6, 1'b0);
		endRequest();
		waitChipDone(startDone + 3);
		verifySlot(3'd4, 8'h10, 5'd0);
		verifySlot(3'd5, 8'h7F, 5'd31);
		verifySlot(3'd6, 8'hC3, 5'd12);
		checkFlag("three chipDone", doneCount == startDone + 3, 1'b1);
	endtask

	task automatic randomBusTest();
		int startDone;
		@(posedge iCLK);
		#1 randomMode = 1'b1;
		startDone = doneCount;
		sendRequest(8'hA5, 5'd19, 3'd7, 1'b0);
		sendRequest(8'h3C, 5'd1, 3'd6, 1'b0);
		endRequest();
		waitChipDone(startDone + 2);
		verifySlot(3'd7, 8'hA5, 5'd19);
		verifySlot(3'd6, 8'h3C, 5'd1);
		#1 randomMode = 1'b0;
	endtask

	task automatic fullQueueTest();
		int startDone;
		@(posedge iCLK);
		#1 stall = 1'b1;
		// Let ufiRdy fall first
		repeat (2)
			@(posedge iCLK);
		startDone = doneCount;
		// First goes to the DMA and two fill the queue so the fourth is lost
		sendRequest(8'h11, 5'd2, 3'd0, 1'b0);
		sendRequest(8'h22, 5'd9, 3'd1, 1'b0);
		sendRequest(8'h33, 5'd30, 3'd3, 1'b0);
		sendRequest(8'h44, 5'd15, 3'd2, 1'b1);
		endRequest();
		repeat (6)
			@(posedge iCLK);
		@(negedge iCLK);
		checkFlag("reqFull", reqFull, 1'b1);
		@(posedge iCLK);
		#1 stall = 1'b0;
		waitChipDone(startDone + 3);
		verifySlot(3'd0, 8'h11, 5'd2);
		verifySlot(3'd1, 8'h22, 5'd9);
		verifySlot(3'd3, 8'h33, 5'd30);
		// Slot 2 still from the first test
		verifySlot(3'd2, 8'd5, 5'd7);
	endtask

	task automatic midResetTest();
		int startDone;
		int startAccepts;
		startAccepts = acceptCount;
		// One line running and two more queued behind it
		sendRequest(8'h09, 5'd3, 3'd0, 1'b0);
		sendRequest(8'h5A, 5'd21, 3'd1, 1'b0);
		sendRequest(8'hE7, 5'd8, 3'd4, 1'b0);
		endRequest();
		waitAccepts(startAccepts + 6);
		@(negedge iCLK);
		checkFlag("reqFull", reqFull, 1'b1);
		@(posedge iCLK);
		#1 holdRst = 1'b1;
		repeat (3)
			@(posedge iCLK);
		#1 holdRst = 1'b0;
		@(negedge iCLK);
		checkFlag("ufiRe", ufiRe, 1'b0);
		checkFlag("chipDone", chipDone, 1'b0);
		checkFlag("reqFull", reqFull, 1'b0);
		// Fresh fetch into the same slot
		startDone = doneCount;
		sendRequest(8'h31, 5'd12, 3'd0, 1'b0);
		endRequest();
		waitChipDone(startDone + 1);
		verifySlot(3'd0, 8'h31, 5'd12);
	endtask

	// ------------------------------
	// Sequence
	// ------------------------------
	initial
	begin
		int limit;
		holdRst = 1'b0;
		reqStrobe = 1'b0;
		reqChipId = '0;
		reqLine = '0;
		reqSlot = '0;
		pixRa = '0;
		stall = 1'b0;
		randomMode = 1'b0;
		limit = 0;
		while (rstN !== 1'b1 && limit < 100)
		begin
			@(posedge iCLK);
			limit++;
		end
		if (rstN !== 1'b1)
		begin
			timeouts++;
			$display("Timeout: reset never released");
		end
		// Idle state after reset
		@(negedge iCLK);
		checkFlag("ufiRe", ufiRe, 1'b0);
		checkFlag("chipDone", chipDone, 1'b0);
		checkFlag("reqFull", reqFull, 1'b0);
		singleFetchTest();
		backToBackTest();
		randomBusTest();
		fullQueueTest();
		midResetTest();
		repeat (4)
			@(posedge iCLK);
		if (expAdrs.size() != 0)
		begin
			errors++;
			$display("%0d requested bus reads never happened", expAdrs.size());
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
common/ufiBusPkg.sv
common/mapChipPkg.sv
common/chipFetchIf.sv
hdl/chipAdrsGen.sv
dma/ufiReadDma.sv
hdl/lineBufWriter.sv
hdl/videoChipFetch.sv
testbench/tbClockGen.sv
testbench/ufiSramModel.sv
testbench/videoChipFetchTb.sv
